/* design/sd_host_pkg.sv */
`default_nettype none

package sd_host_pkg;

    typedef logic [6:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [7:0]  clk_div_t;
    // counted in sd clock cycles
    typedef logic [15:0] cmd_timeout_t;

    // host register map
    localparam reg_addr_t ADDR_ARGUMENT   = 7'h08;
    localparam reg_addr_t ADDR_COMMAND    = 7'h0C;
    localparam reg_addr_t ADDR_RESPONSE   = 7'h10;
    localparam reg_addr_t ADDR_PRESENT    = 7'h24;
    localparam reg_addr_t ADDR_CLK_DIV    = 7'h2C;
    localparam reg_addr_t ADDR_TIMEOUT    = 7'h2E;
    localparam reg_addr_t ADDR_INT_STATUS = 7'h30;
    localparam reg_addr_t ADDR_INT_ENABLE = 7'h34;

    // status and enable share one layout, cmd_complete in bit 0
    typedef struct packed {
        logic index_err;
        logic crc_err;
        logic timeout;
        logic cmd_complete;
    } int_status_t;

endpackage

`default_nettype wire

/* design/sd_cmd_pkg.sv */
`default_nettype none

package sd_cmd_pkg;

    typedef logic [5:0]  cmd_index_t;
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0]  crc7_t;
    // bit position inside a command or response frame
    typedef logic [5:0]  frame_bit_t;

    localparam frame_bit_t CMD_FRAME_BITS   = 6'd48;
    localparam frame_bit_t CMD_PAYLOAD_BITS = 6'd40;

    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1
    } resp_type_e;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   argument;
        resp_type_e resp_type;
        logic       check_index;
    } cmd_req_t;

    typedef struct packed {
        cmd_arg_t   response;
        cmd_index_t resp_index;
        logic       crc_ok;
        logic       got_response;
    } cmd_result_t;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_SEND,
        CMD_WAIT,
        CMD_DONE
    } cmd_state_e;

    // one step of x^7 + x^3 + 1, msb first
    function automatic crc7_t crc7_next(input crc7_t crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
    endfunction

endpackage

`default_nettype wire

/* design/sd_clock_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_clock_divider #(
    parameter sd_host_pkg::clk_div_t RESET_DIV = 8'd4
) (
    input  wire                    aclk,
    input  wire                    reset_i,
    input  wire sd_host_pkg::clk_div_t clk_div_i,
    output logic                   sd_clk_o,
    output logic                   drive_en_o,
    output logic                   sample_en_o
);
    import sd_host_pkg::*;

    clk_div_t div_q;
    clk_div_t half_cnt_q;
    logic     boundary;

    // last aclk of a half period before sd_clk toggles
    assign boundary    = (half_cnt_q == div_q);
    assign drive_en_o  = boundary && sd_clk_o;
    assign sample_en_o = boundary && !sd_clk_o;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            div_q      <= RESET_DIV;
            half_cnt_q <= '0;
            sd_clk_o   <= 1'b0;
        end else if (boundary) begin
            // new divisor only at a half period edge
            div_q      <= clk_div_i;
            half_cnt_q <= '0;
            sd_clk_o   <= !sd_clk_o;
        end else begin
            half_cnt_q <= half_cnt_q + 8'd1;
        end
    end

    // counter never runs past the current divisor
    assert property (@(posedge aclk) disable iff (reset_i)
        half_cnt_q <= div_q);

endmodule

`default_nettype wire

/* design/sd_cmd_serial.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_serial (
    input  wire                         aclk,
    input  wire                         reset_i,
    input  wire sd_cmd_pkg::cmd_req_t   req_i,
    input  wire                         tx_start_i,
    input  wire                         rx_start_i,
    input  wire                         rx_abort_i,
    input  wire                         drive_en_i,
    input  wire                         sample_en_i,
    input  wire                         cmd_i,
    output logic                        cmd_o,
    output logic                        cmd_oe_o,
    output logic                        tx_done_o,
    output logic                        rx_done_o,
    output sd_cmd_pkg::cmd_result_t     result_o
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_TX,
        SER_RX_WAIT,
        SER_RX
    } ser_state_e;

    localparam frame_bit_t LAST_BIT = CMD_FRAME_BITS - 6'd1;

    ser_state_e  state_q;
    frame_bit_t  bit_cnt_q;
    crc7_t       crc_q;
    logic [45:0] shift_q;
    logic        tx_bit;
    logic        shift_in;

    // payload, then crc, then end bit
    assign tx_bit = (bit_cnt_q < CMD_PAYLOAD_BITS) ? shift_q[45] :
                    (bit_cnt_q == LAST_BIT) ? 1'b1 : crc_q[6];
    assign shift_in  = (state_q == SER_RX) ? cmd_i : 1'b0;
    // line is released on the drive edge after the end bit
    assign tx_done_o = (state_q == SER_TX) && drive_en_i && (bit_cnt_q == CMD_FRAME_BITS);

    always_ff @(posedge aclk) begin
        if (tx_start_i && state_q == SER_IDLE) begin
            shift_q <= {2'b01, req_i.index, req_i.argument, 6'b0};
        end else if ((state_q == SER_TX && drive_en_i) || (state_q == SER_RX && sample_en_i)) begin
            shift_q <= {shift_q[44:0], shift_in};
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q   <= SER_IDLE;
            bit_cnt_q <= '0;
            crc_q     <= '0;
            cmd_o     <= 1'b1;
            cmd_oe_o  <= 1'b0;
            rx_done_o <= 1'b0;
            result_o  <= '0;
        end else begin
            rx_done_o <= 1'b0;
            case (state_q)
                SER_IDLE: begin
                    if (tx_start_i) begin
                        bit_cnt_q <= '0;
                        crc_q     <= '0;
                        result_o.got_response <= 1'b0;
                        state_q   <= SER_TX;
                    end
                end
                SER_TX: begin
                    if (drive_en_i && bit_cnt_q == CMD_FRAME_BITS) begin
                        cmd_o    <= 1'b1;
                        cmd_oe_o <= 1'b0;
                        state_q  <= rx_start_i ? SER_RX_WAIT : SER_IDLE;
                    end else if (drive_en_i) begin
                        cmd_o     <= tx_bit;
                        cmd_oe_o  <= 1'b1;
                        bit_cnt_q <= bit_cnt_q + 6'd1;
                        if (bit_cnt_q < CMD_PAYLOAD_BITS) begin
                            crc_q <= crc7_next(crc_q, tx_bit);
                        end else begin
                            crc_q <= {crc_q[5:0], 1'b0};
                        end
                    end
                end
                SER_RX_WAIT: begin
                    if (rx_abort_i) begin
                        state_q <= SER_IDLE;
                    end else if (sample_en_i && !cmd_i) begin
                        // start bit leaves a zero crc unchanged
                        bit_cnt_q <= 6'd1;
                        crc_q     <= '0;
                        state_q   <= SER_RX;
                    end
                end
                default: begin
                    if (rx_abort_i) begin
                        state_q <= SER_IDLE;
                    end else if (sample_en_i && bit_cnt_q == LAST_BIT) begin
                        result_o <= '{response:     shift_q[38:7],
                                      resp_index:   shift_q[44:39],
                                      crc_ok:       (shift_q[6:0] == crc_q),
                                      got_response: 1'b1};
                        rx_done_o <= 1'b1;
                        state_q   <= SER_IDLE;
                    end else if (sample_en_i) begin
                        bit_cnt_q <= bit_cnt_q + 6'd1;
                        if (bit_cnt_q < CMD_PAYLOAD_BITS) begin
                            crc_q <= crc7_next(crc_q, cmd_i);
                        end
                    end
                end
            endcase
        end
    end

    assert property (@(posedge aclk) disable iff (reset_i)
        !(cmd_oe_o && (state_q == SER_RX_WAIT || state_q == SER_RX)));

endmodule

`default_nettype wire

/* design/sd_cmd_master.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_master (
    input  wire                             aclk,
    input  wire                             reset_i,
    input  wire                             cmd_start_i,
    input  wire sd_cmd_pkg::resp_type_e     resp_type_i,
    input  wire                             check_index_i,
    input  wire sd_cmd_pkg::cmd_index_t     expect_index_i,
    input  wire sd_host_pkg::cmd_timeout_t  timeout_i,
    input  wire                             sample_en_i,
    input  wire                             tx_done_i,
    input  wire                             rx_done_i,
    input  wire sd_cmd_pkg::cmd_result_t    result_i,
    output logic                            tx_start_o,
    output logic                            rx_start_o,
    output logic                            rx_abort_o,
    output logic                            busy_o,
    output logic                            result_valid_o,
    output sd_host_pkg::int_status_t        result_status_o
);
    import sd_cmd_pkg::*;
    import sd_host_pkg::*;

    cmd_state_e   state_q;
    cmd_timeout_t wait_cnt_q;
    int_status_t  status_q;
    logic         expect_resp;
    logic         timed_out;

    assign expect_resp = (resp_type_i == RESP_SHORT);
    assign timed_out   = (wait_cnt_q == timeout_i);

    assign tx_start_o      = (state_q == CMD_IDLE) && cmd_start_i;
    assign rx_start_o      = (state_q == CMD_SEND) && tx_done_i && expect_resp;
    assign rx_abort_o      = (state_q == CMD_WAIT) && !rx_done_i && timed_out;
    assign busy_o          = (state_q != CMD_IDLE);
    assign result_valid_o  = (state_q == CMD_DONE);
    assign result_status_o = status_q;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q    <= CMD_IDLE;
            wait_cnt_q <= '0;
            status_q   <= '0;
        end else begin
            case (state_q)
                CMD_IDLE: begin
                    if (cmd_start_i) begin
                        status_q <= '0;
                        state_q  <= CMD_SEND;
                    end
                end
                CMD_SEND: begin
                    if (tx_done_i) begin
                        wait_cnt_q <= '0;
                        if (expect_resp) begin
                            state_q <= CMD_WAIT;
                        end else begin
                            status_q.cmd_complete <= 1'b1;
                            state_q <= CMD_DONE;
                        end
                    end
                end
                CMD_WAIT: begin
                    // a response landing with the timeout still counts
                    if (rx_done_i) begin
                        status_q.cmd_complete <= result_i.got_response;
                        status_q.crc_err      <= !result_i.crc_ok;
                        status_q.index_err    <= check_index_i &&
                                                 (result_i.resp_index != expect_index_i);
                        state_q <= CMD_DONE;
                    end else if (timed_out) begin
                        status_q.timeout <= 1'b1;
                        state_q <= CMD_DONE;
                    end else if (sample_en_i) begin
                        wait_cnt_q <= wait_cnt_q + 16'd1;
                    end
                end
                default: begin
                    state_q <= CMD_IDLE;
                end
            endcase
        end
    end

    // every start request finds the FSM idle
    assert property (@(posedge aclk) disable iff (reset_i)
        cmd_start_i |-> tx_start_o);

endmodule

`default_nettype wire

/* design/sd_host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_host_regs #(
    parameter sd_host_pkg::clk_div_t     RESET_DIV     = 8'd4,
    parameter sd_host_pkg::cmd_timeout_t RESET_TIMEOUT = 16'd64
) (
    input  wire                            aclk,
    input  wire                            reset_i,
    input  wire                            reg_wr_i,
    input  wire sd_host_pkg::reg_addr_t    reg_addr_i,
    input  wire sd_host_pkg::reg_data_t    reg_wdata_i,
    input  wire                            busy_i,
    input  wire                            result_valid_i,
    input  wire sd_host_pkg::int_status_t  result_status_i,
    input  wire sd_cmd_pkg::cmd_arg_t      response_i,
    output sd_host_pkg::reg_data_t         reg_rdata_o,
    output sd_cmd_pkg::cmd_req_t           cmd_req_o,
    output logic                           cmd_start_o,
    output sd_host_pkg::clk_div_t          clk_div_o,
    output sd_host_pkg::cmd_timeout_t      timeout_o,
    output logic                           interrupt_o
);
    import sd_host_pkg::*;
    import sd_cmd_pkg::*;

    cmd_arg_t     argument_q;
    cmd_arg_t     response_q;
    cmd_index_t   index_q;
    resp_type_e   resp_type_q;
    logic         check_index_q;
    clk_div_t     clk_div_q;
    cmd_timeout_t timeout_q;
    int_status_t  status_q;
    int_status_t  enable_q;
    int_status_t  status_clr;
    int_status_t  status_set;
    logic         inhibit;
    logic         wr_cmd;

    // pending start pulse counts as busy too
    assign inhibit    = busy_i || cmd_start_o;
    assign wr_cmd     = reg_wr_i && (reg_addr_i == ADDR_COMMAND) && !inhibit;
    assign status_clr = (reg_wr_i && reg_addr_i == ADDR_INT_STATUS) ?
                        int_status_t'(reg_wdata_i[3:0]) : '0;
    assign status_set = result_valid_i ? result_status_i : '0;

    assign cmd_req_o = '{index: index_q, argument: argument_q,
                         resp_type: resp_type_q, check_index: check_index_q};
    assign clk_div_o   = clk_div_q;
    assign timeout_o   = timeout_q;
    assign interrupt_o = |(status_q & enable_q);

    always_ff @(posedge aclk) begin
        if (reg_wr_i && reg_addr_i == ADDR_ARGUMENT) begin
            argument_q <= reg_wdata_i;
        end
        if (result_valid_i) begin
            response_q <= response_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            index_q       <= '0;
            resp_type_q   <= RESP_NONE;
            check_index_q <= 1'b0;
            clk_div_q     <= RESET_DIV;
            timeout_q     <= RESET_TIMEOUT;
            status_q      <= '0;
            enable_q      <= '0;
            cmd_start_o   <= 1'b0;
        end else begin
            cmd_start_o <= wr_cmd;
            if (wr_cmd) begin
                index_q       <= reg_wdata_i[5:0];
                resp_type_q   <= resp_type_e'(reg_wdata_i[9:8]);
                check_index_q <= reg_wdata_i[12];
            end
            if (reg_wr_i) begin
                case (reg_addr_i)
                    ADDR_CLK_DIV:    clk_div_q <= reg_wdata_i[7:0];
                    ADDR_TIMEOUT:    timeout_q <= reg_wdata_i[15:0];
                    ADDR_INT_ENABLE: enable_q  <= int_status_t'(reg_wdata_i[3:0]);
                    default: ;
                endcase
            end
            // new events win over a clear in the same cycle
            status_q <= int_status_t'((status_q & ~status_clr) | status_set);
        end
    end

    always_comb begin
        case (reg_addr_i)
            ADDR_ARGUMENT:   reg_rdata_o = argument_q;
            ADDR_COMMAND:    reg_rdata_o = {19'b0, check_index_q, 2'b0, resp_type_q,
                                            2'b0, index_q};
            ADDR_RESPONSE:   reg_rdata_o = response_q;
            ADDR_PRESENT:    reg_rdata_o = {31'b0, inhibit};
            ADDR_CLK_DIV:    reg_rdata_o = {24'b0, clk_div_q};
            ADDR_TIMEOUT:    reg_rdata_o = {16'b0, timeout_q};
            ADDR_INT_STATUS: reg_rdata_o = {28'b0, status_q};
            ADDR_INT_ENABLE: reg_rdata_o = {28'b0, enable_q};
            default:         reg_rdata_o = '0;
        endcase
    end

    assert property (@(posedge aclk) disable iff (reset_i)
        cmd_start_o |-> !busy_i);

endmodule

`default_nettype wire

/* design/sd_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_top #(
    parameter sd_host_pkg::clk_div_t     RESET_DIV     = 8'd4,
    parameter sd_host_pkg::cmd_timeout_t RESET_TIMEOUT = 16'd64
) (
    input  wire                         aclk,
    input  wire                         reset_i,
    input  wire                         reg_wr_i,
    input  wire sd_host_pkg::reg_addr_t reg_addr_i,
    input  wire sd_host_pkg::reg_data_t reg_wdata_i,
    output sd_host_pkg::reg_data_t      reg_rdata_o,
    output logic                        sd_clk_o,
    output logic                        cmd_o,
    output logic                        cmd_oe_o,
    input  wire                         cmd_i,
    output logic                        interrupt_o
);
    import sd_host_pkg::*;
    import sd_cmd_pkg::*;

    cmd_req_t     cmd_req;
    cmd_result_t  cmd_result;
    clk_div_t     clk_div;
    cmd_timeout_t cmd_timeout;
    int_status_t  result_status;
    logic         cmd_start;
    logic         busy;
    logic         result_valid;
    logic         drive_en;
    logic         sample_en;
    logic         tx_start;
    logic         tx_done;
    logic         rx_start;
    logic         rx_done;
    logic         rx_abort;

    sd_host_regs #(
        .RESET_DIV     (RESET_DIV),
        .RESET_TIMEOUT (RESET_TIMEOUT)
    ) sd_host_regs_i (
        .aclk            (aclk),
        .reset_i         (reset_i),
        .reg_wr_i        (reg_wr_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .busy_i          (busy),
        .result_valid_i  (result_valid),
        .result_status_i (result_status),
        .response_i      (cmd_result.response),
        .reg_rdata_o     (reg_rdata_o),
        .cmd_req_o       (cmd_req),
        .cmd_start_o     (cmd_start),
        .clk_div_o       (clk_div),
        .timeout_o       (cmd_timeout),
        .interrupt_o     (interrupt_o)
    );

    sd_clock_divider #(
        .RESET_DIV (RESET_DIV)
    ) sd_clock_divider_i (
        .aclk        (aclk),
        .reset_i     (reset_i),
        .clk_div_i   (clk_div),
        .sd_clk_o    (sd_clk_o),
        .drive_en_o  (drive_en),
        .sample_en_o (sample_en)
    );

    sd_cmd_master sd_cmd_master_i (
        .aclk            (aclk),
        .reset_i         (reset_i),
        .cmd_start_i     (cmd_start),
        .resp_type_i     (cmd_req.resp_type),
        .check_index_i   (cmd_req.check_index),
        .expect_index_i  (cmd_req.index),
        .timeout_i       (cmd_timeout),
        .sample_en_i     (sample_en),
        .tx_done_i       (tx_done),
        .rx_done_i       (rx_done),
        .result_i        (cmd_result),
        .tx_start_o      (tx_start),
        .rx_start_o      (rx_start),
        .rx_abort_o      (rx_abort),
        .busy_o          (busy),
        .result_valid_o  (result_valid),
        .result_status_o (result_status)
    );

    sd_cmd_serial sd_cmd_serial_i (
        .aclk        (aclk),
        .reset_i     (reset_i),
        .req_i       (cmd_req),
        .tx_start_i  (tx_start),
        .rx_start_i  (rx_start),
        .rx_abort_i  (rx_abort),
        .drive_en_i  (drive_en),
        .sample_en_i (sample_en),
        .cmd_i       (cmd_i),
        .cmd_o       (cmd_o),
        .cmd_oe_o    (cmd_oe_o),
        .tx_done_o   (tx_done),
        .rx_done_o   (rx_done),
        .result_o    (cmd_result)
    );

endmodule

`default_nettype wire

/* tests/sd_card_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
    input  wire         sd_clk_i,
    input  wire         cmd_i,
    input  wire         silent_i,
    input  wire         bad_crc_i,
    input  wire         bad_index_i,
    output logic        cmd_o,
    output logic        replying_o,
    output logic [47:0] frame_o,
    output int          frame_count_o
);

    logic [47:0] rx;
    logic [47:0] reply;
    logic [5:0]  idx;

    // x^7 + x^3 + 1 over the first 40 bits, msb first
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = 7'h00;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    initial begin
        cmd_o         = 1'b1;
        replying_o    = 1'b0;
        frame_o       = '0;
        frame_count_o = 0;
        rx            = '0;
        forever begin
            @(posedge sd_clk_i);
            if (cmd_i == 1'b0) begin
                rx[47] = 1'b0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk_i);
                    rx[i] = cmd_i;
                end
                frame_o       = rx;
                frame_count_o = frame_count_o + 1;
                if (!silent_i) begin
                    idx          = rx[45:40] + (bad_index_i ? 6'd1 : 6'd0);
                    reply[47:8]  = {2'b00, idx, rx[39:8] ^ 32'h5a5a_a5a5};
                    reply[7:0]   = {crc7(reply[47:8]) ^ {6'b0, bad_crc_i}, 1'b1};
                    repeat (2) @(posedge sd_clk_i);
                    replying_o = 1'b1;
                    // card drives after the falling sd clock edge
                    for (int i = 47; i >= 0; i--) begin
                        @(negedge sd_clk_i);
                        #1 cmd_o = reply[i];
                    end
                    @(negedge sd_clk_i);
                    #1 cmd_o = 1'b1;
                    replying_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_sd_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sd_cmd;
    import sd_host_pkg::*;
    import sd_cmd_pkg::*;

    localparam int          RESET_DIV = 4;
    localparam logic [31:0] RESP_MASK = 32'h5a5a_a5a5;

    logic        aclk;
    logic        reset_i;
    logic        reg_wr_i;
    reg_addr_t   reg_addr_i;
    reg_data_t   reg_wdata_i;
    reg_data_t   reg_rdata;
    logic        sd_clk;
    logic        cmd_out;
    logic        cmd_oe;
    logic        card_cmd;
    logic        interrupt;
    logic        line;
    logic        silent;
    logic        bad_crc;
    logic        bad_index;
    logic        card_busy;
    logic [47:0] card_frame;
    int          frames;
    logic        irq_enabled;
    int          error_count;
    int          cycles;
    int          count;
    cmd_index_t  idx;
    cmd_arg_t    arg;
    reg_data_t   rd;

    // released line is pulled high
    assign line = cmd_oe ? cmd_out : 1'b1;

    sd_cmd_top #(
        .RESET_DIV (RESET_DIV)
    ) dut_i (
        .aclk        (aclk),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata),
        .sd_clk_o    (sd_clk),
        .cmd_o       (cmd_out),
        .cmd_oe_o    (cmd_oe),
        .cmd_i       (card_cmd),
        .interrupt_o (interrupt)
    );

    sd_card_model card_i (
        .sd_clk_i      (sd_clk),
        .cmd_i         (line),
        .silent_i      (silent),
        .bad_crc_i     (bad_crc),
        .bad_index_i   (bad_index),
        .cmd_o         (card_cmd),
        .replying_o    (card_busy),
        .frame_o       (card_frame),
        .frame_count_o (frames)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #5 aclk = ~aclk;
        end
    end

    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = 7'h00;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_equal(input string name, input logic [47:0] expected,
                               input logic [47:0] actual);
        assert (actual === expected)
            else report_failure($sformatf("FAILED %s: expected %h, actual %h",
                                          name, expected, actual));
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge aclk);
        #1;
        if (addr == ADDR_INT_ENABLE) begin
            irq_enabled = (data[3:0] != 4'h0);
        end
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(posedge aclk);
        #1;
        reg_wr_i = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge aclk);
        #1;
        reg_addr_i = addr;
        #4;
        data = reg_rdata;
    endtask

    // aclk cycles up to the next rising sd_clk_o
    task automatic wait_sd_rise(output int n);
        logic prev;
        logic rise;
        prev = sd_clk;
        rise = 1'b0;
        n    = 0;
        while (!rise) begin
            @(posedge aclk);
            #2;
            n++;
            if (n > 600) begin
                report_failure("timeout: sd_clk_o stopped toggling");
            end
            rise = sd_clk && !prev;
            prev = sd_clk;
        end
    endtask

    task automatic start_command(input cmd_index_t index, input cmd_arg_t argument,
                                 input resp_type_e resp, input logic chk);
        reg_write(ADDR_INT_STATUS, 32'hf);
        reg_write(ADDR_ARGUMENT, argument);
        reg_write(ADDR_COMMAND, {19'b0, chk, 2'b0, resp, 2'b0, index});
    endtask

    task automatic finish_command(input string name, input logic [3:0] expected);
        reg_data_t status;
        int        n;
        status = '0;
        n      = 0;
        // completion or timeout ends every command
        while (status[1:0] == 2'b00) begin
            if (n == 2000) begin
                report_failure($sformatf("timeout: the %s command never finished", name));
            end
            reg_read(ADDR_INT_STATUS, status);
            n++;
        end
        check_equal({name, " status"}, expected, status[3:0]);
    endtask

    task automatic wait_present_busy();
        reg_data_t present;
        int        n;
        present = '0;
        n       = 0;
        while (present[0] == 1'b0) begin
            if (n == 100) begin
                report_failure("timeout: PRESENT bit 0 never set after a command write");
            end
            reg_read(ADDR_PRESENT, present);
            n++;
        end
    endtask

    assert property (@(posedge aclk) disable iff (reset_i) card_busy |-> !cmd_oe)
        else report_failure("host drove the command line during a card reply");

    assert property (@(posedge aclk) disable iff (reset_i) $rose(interrupt) |-> irq_enabled)
        else report_failure("interrupt_o rose while its enable was clear");

    initial begin
        void'($urandom(32'h8f4b));
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        silent      = 1'b0;
        bad_crc     = 1'b0;
        bad_index   = 1'b0;
        irq_enabled = 1'b0;
        error_count = 0;
        repeat (5) @(posedge aclk);
        #1 reset_i = 1'b0;

        check_equal("reset cmd_oe", 0, cmd_oe);
        check_equal("reset interrupt", 0, interrupt);
        reg_read(ADDR_INT_STATUS, rd);
        check_equal("reset status", 0, rd);
        wait_sd_rise(cycles);
        wait_sd_rise(cycles);
        check_equal("reset sd period", 2 * (RESET_DIV + 1), cycles);
        reg_write(ADDR_CLK_DIV, 32'd1);
        repeat (3) wait_sd_rise(cycles);
        check_equal("divided sd period", 4, cycles);

        // short response with correct crc and index
        idx = cmd_index_t'($urandom());
        arg = $urandom();
        start_command(idx, arg, RESP_SHORT, 1'b1);
        finish_command("short", 4'b0001);
        check_equal("frame", {2'b01, idx, arg, crc7({2'b01, idx, arg}), 1'b1}, card_frame);
        reg_read(ADDR_RESPONSE, rd);
        check_equal("response", arg ^ RESP_MASK, rd);
        check_equal("interrupt disabled", 0, interrupt);
        reg_write(ADDR_INT_ENABLE, 32'h1);
        check_equal("interrupt enabled", 1, interrupt);
        reg_write(ADDR_INT_STATUS, 32'h1);
        check_equal("interrupt cleared", 0, interrupt);
        reg_read(ADDR_INT_STATUS, rd);
        check_equal("status cleared", 0, rd);

        // no response with a second write while busy
        silent = 1'b1;
        count  = frames;
        idx    = cmd_index_t'($urandom());
        arg    = $urandom();
        start_command(idx, arg, RESP_NONE, 1'b0);
        wait_present_busy();
        reg_write(ADDR_COMMAND, {19'b0, 1'b1, 2'b0, RESP_SHORT, 2'b0, idx});
        finish_command("no response", 4'b0001);
        repeat (300) @(posedge aclk);
        check_equal("frames sent", count + 1, frames);

        start_command(cmd_index_t'($urandom()), $urandom(), RESP_SHORT, 1'b1);
        finish_command("silent card", 4'b0010);

        silent  = 1'b0;
        bad_crc = 1'b1;
        start_command(cmd_index_t'($urandom()), $urandom(), RESP_SHORT, 1'b1);
        finish_command("bad crc", 4'b0101);
        bad_crc   = 1'b0;
        bad_index = 1'b1;
        start_command(cmd_index_t'($urandom()), $urandom(), RESP_SHORT, 1'b1);
        finish_command("bad index checked", 4'b1001);
        start_command(cmd_index_t'($urandom()), $urandom(), RESP_SHORT, 1'b0);
        finish_command("bad index unchecked", 4'b0001);

        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "simulation stopped after a failed check");
        end
    end

endmodule

`default_nettype wire

/* tb.f */
design/sd_host_pkg.sv
design/sd_cmd_pkg.sv
design/sd_clock_divider.sv
design/sd_cmd_serial.sv
design/sd_cmd_master.sv
design/sd_host_regs.sv
design/sd_cmd_top.sv
tests/sd_card_model.sv
tests/tb_sd_cmd.sv

/* Bender.yml */
package:
  name: sd_cmd_host

sources:
  - files:
      - design/sd_host_pkg.sv
      - design/sd_cmd_pkg.sv
      - design/sd_clock_divider.sv
      - design/sd_cmd_serial.sv
      - design/sd_cmd_master.sv
      - design/sd_host_regs.sv
      - design/sd_cmd_top.sv
  - target: test
    files:
      - tests/sd_card_model.sv
      - tests/tb_sd_cmd.sv
